// File: synth_kbd_top.f
rtl/synth_kbd_pkg.sv
rtl/ps2_rx.sv
rtl/scancode_parser.sv
rtl/key_mapper.sv
rtl/synth_params.sv
rtl/synth_kbd_top.sv
testbench/tb_clock_gen.sv
testbench/tb_synth_kbd.sv

// File: Bender.yml
package:
  name: synth_kbd

sources:
  - files:
      - rtl/synth_kbd_pkg.sv
      - rtl/ps2_rx.sv
      - rtl/scancode_parser.sv
      - rtl/key_mapper.sv
      - rtl/synth_params.sv
      - rtl/synth_kbd_top.sv

  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_synth_kbd.sv

// File: testbench/tb_synth_kbd.sv
`timescale 1ns/1ps

module tb_synth_kbd;
    import synth_kbd_pkg::*;

    localparam int  HALF_BIT     = 20;   // Keyboard half-period in system cycles
    localparam int  FRAME_BUDGET = 110;  // Upper bound on frames sent
    localparam real WATCHDOG_NS  = 1.5 * FRAME_BUDGET * (22.0 * 40.0 * 40.0 + 200.0 * 40.0);

    logic         PS2_CLK;
    logic         reset;
    logic         kbd_clk;
    logic         kbd_dat;
    note_out_t    note_out;
    synth_state_t state;
    logic         frame_error;

    // Reference model
    synth_state_t exp_state;
    int           exp_oct;
    int           exp_sel;
    int           exp_env [NUM_ENV];
    logic [3:0]   exp_note;
    logic         exp_gate;
    logic         note_pending;  // A note make is on its way
    logic         check_now;
    int           on_count;
    int           err_count;
    int           exp_on_count;
    int           exp_err_count;

    logic [7:0] note_keys [NUM_NOTES] = '{SC_A, SC_W, SC_S, SC_E, SC_D, SC_F,
                                          SC_T, SC_G, SC_Y, SC_H, SC_U, SC_J};
    logic [7:0] sel_keys [NUM_ENV] = '{SC_1, SC_2, SC_3, SC_4, SC_5};

    tb_clock_gen u_tb_clock_gen
    (
        .PS2_CLK (PS2_CLK),
        .reset   (reset)
    );

    synth_kbd_top u_synth_kbd_top
    (
        .PS2_CLK     (PS2_CLK),
        .reset       (reset),
        .kbd_clk     (kbd_clk),
        .kbd_dat     (kbd_dat),
        .note_out    (note_out),
        .state       (state),
        .frame_error (frame_error)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge PS2_CLK);
    endtask

    function automatic int note_index(input logic [7:0] code);
        int idx;
        idx = -1;
        for (int i = 0; i < NUM_NOTES; i++)
            if (code == note_keys[i])
                idx = i;
        return idx;
    endfunction

    task automatic update_expected_state();
        exp_state.octave  = exp_oct[2:0];
        exp_state.env_sel = exp_sel[2:0];
        for (int i = 0; i < NUM_ENV; i++)
            exp_state.env[i] = exp_env[i][ENV_BITS-1:0];
    endtask

    task automatic apply_key(input logic [7:0] code, input bit rel);
        int n;
        n = note_index(code);
        if (n >= 0)
        begin
            if (!rel)
            begin
                exp_note     = 4'(n);
                exp_gate     = 1'b1;
                note_pending = 1'b1;
                exp_on_count++;
            end
            else if (n == exp_note)
                exp_gate = 1'b0;  // Held note let go
        end
        else if (!rel)
        begin
            for (int i = 0; i < NUM_ENV; i++)
                if (code == sel_keys[i])
                    exp_sel = i;
            if (code == SC_Z && exp_oct > OCT_MIN)
                exp_oct--;
            else if (code == SC_X && exp_oct < OCT_MAX)
                exp_oct++;
            else if (code == SC_C && exp_env[exp_sel] > 0)
                exp_env[exp_sel]--;
            else if (code == SC_V && exp_env[exp_sel] < (1 << ENV_BITS) - 1)
                exp_env[exp_sel]++;
        end
        update_expected_state();
    endtask

    // Start, eight data bits LSB first, parity, stop
    task automatic send_frame(input logic [7:0] data, input bit bad_parity, input bit bad_stop);
        logic [10:0] bits;
        int          gap;
        bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
        gap  = 30 + ($urandom % 171);
        for (int i = 0; i < 11; i++)
        begin
            kbd_dat <= bits[i];
            wait_cycles(HALF_BIT / 2);
            kbd_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            kbd_clk <= 1'b1;
            wait_cycles(HALF_BIT / 2);
        end
        kbd_dat <= 1'b1;
        wait_cycles(gap);
    endtask

    task automatic settle();
        check_now <= 1'b1;
        wait_cycles(1);
        check_now    <= 1'b0;
        note_pending = 1'b0;
    endtask

    task automatic key_seq(input logic [7:0] code, input bit rel, input bit ext);
        if (ext)
            send_frame(CODE_EXT, 1'b0, 1'b0);
        if (rel)
            send_frame(CODE_BREAK, 1'b0, 1'b0);
        if (!ext)
            apply_key(code, rel);  // Extended sequences are dropped whole
        send_frame(code, 1'b0, 1'b0);
        settle();
    endtask

    task automatic bad_frame(input logic [7:0] data, input bit bad_parity, input bit bad_stop);
        exp_err_count++;
        send_frame(data, bad_parity, bad_stop);
        settle();
    endtask

    always @(posedge PS2_CLK)
    begin
        if (note_out.note_on)
            on_count <= on_count + 1;
        if (frame_error)
            err_count <= err_count + 1;
    end

    assert property (@(posedge PS2_CLK) disable iff (reset) note_out.note_on |-> note_pending)
        else abort_run("note_on pulsed although no note key was pressed");
    assert property (@(posedge PS2_CLK) disable iff (reset)
        note_out.note_on |-> (note_out.note == exp_note && note_out.gate))
        else abort_run($sformatf("FAIL note_out.note/gate expected %h/1 got %h/%h",
            exp_note, note_out.note, note_out.gate));
    assert property (@(posedge PS2_CLK) check_now |-> (state == exp_state))
        else abort_run($sformatf("FAIL state expected %h got %h", exp_state, state));
    assert property (@(posedge PS2_CLK) check_now |->
        (note_out.gate == exp_gate && note_out.note == exp_note))
        else abort_run($sformatf("FAIL note_out.gate/note expected %h/%h got %h/%h",
            exp_gate, exp_note, note_out.gate, note_out.note));
    assert property (@(posedge PS2_CLK) check_now |->
        (on_count == exp_on_count && err_count == exp_err_count))
        else abort_run($sformatf("FAIL note_on/frame_error counts expected %h/%h got %h/%h",
            exp_on_count, exp_err_count, on_count, err_count));
    assert property (@(posedge PS2_CLK) check_now |-> !(note_out.note_on || frame_error))
        else abort_run("A strobe was still active at the end of a settling window");

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired, the run hung before the tests finished");
    end

    initial
    begin
        void'($urandom(16379));
        kbd_clk       = 1'b1;  // Both lines idle high
        kbd_dat       = 1'b1;
        check_now     = 1'b0;
        note_pending  = 1'b0;
        on_count      = 0;
        err_count     = 0;
        exp_on_count  = 0;
        exp_err_count = 0;
        exp_oct       = 0;
        exp_sel       = 0;
        exp_note      = '0;
        exp_gate      = 1'b0;
        for (int i = 0; i < NUM_ENV; i++)
            exp_env[i] = ENV_DEFAULT;
        update_expected_state();
        @(negedge reset);
        wait_cycles(1);
        settle();  // Reset values

        for (int i = 0; i < NUM_NOTES; i++)
        begin
            key_seq(note_keys[i], 1'b0, 1'b0);
            key_seq(note_keys[i], 1'b1, 1'b0);
        end
        key_seq(SC_E, 1'b0, 1'b0);
        key_seq(SC_J, 1'b1, 1'b0);  // Other note's break keeps gate
        key_seq(SC_E, 1'b1, 1'b0);

        repeat (4) key_seq(SC_Z, 1'b0, 1'b0);
        repeat (7) key_seq(SC_X, 1'b0, 1'b0);
        key_seq(SC_Z, 1'b0, 1'b0);

        key_seq(SC_1, 1'b0, 1'b0);
        repeat (8) key_seq(SC_V, 1'b0, 1'b0);  // Volume tops out at 15
        key_seq(SC_4, 1'b0, 1'b0);
        repeat (9) key_seq(SC_C, 1'b0, 1'b0);  // Sustain bottoms out at 0
        key_seq(SC_2, 1'b0, 1'b0);
        repeat (2) key_seq(SC_V, 1'b0, 1'b0);
        key_seq(SC_C, 1'b0, 1'b0);
        key_seq(SC_3, 1'b0, 1'b0);
        key_seq(SC_C, 1'b0, 1'b0);
        key_seq(SC_5, 1'b0, 1'b0);
        key_seq(SC_V, 1'b0, 1'b0);

        bad_frame(SC_A, 1'b1, 1'b0);
        key_seq(SC_D, 1'b0, 1'b0);
        bad_frame(SC_X, 1'b0, 1'b1);
        send_frame(CODE_BREAK, 1'b0, 1'b0);
        bad_frame(SC_H, 1'b1, 1'b0);  // Error drops the pending break
        key_seq(SC_G, 1'b0, 1'b0);

        key_seq(SC_A, 1'b0, 1'b1);
        key_seq(SC_G, 1'b1, 1'b1);
        key_seq(SC_X, 1'b1, 1'b1);
        key_seq(8'h15, 1'b0, 1'b0);  // Unmapped key
        key_seq(8'h15, 1'b1, 1'b0);
        key_seq(SC_Z, 1'b1, 1'b0);
        key_seq(SC_V, 1'b1, 1'b0);
        key_seq(SC_3, 1'b1, 1'b0);
        key_seq(SC_G, 1'b1, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic PS2_CLK,
    output logic reset
);
    localparam real HALF_PERIOD  = 20.0;  // 40 ns system clock
    localparam int  RESET_CYCLES = 8;

    initial
    begin
        PS2_CLK = 1'b0;
        forever
            #(HALF_PERIOD) PS2_CLK = ~PS2_CLK;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge PS2_CLK);
        reset <= 1'b0;
    end

endmodule

// File: rtl/synth_kbd_top.sv
`timescale 1ns/1ps

module synth_kbd_top
(
    input  logic                        PS2_CLK,
    input  logic                        reset,
    input  logic                        kbd_clk,
    input  logic                        kbd_dat,
    output synth_kbd_pkg::note_out_t    note_out,
    output synth_kbd_pkg::synth_state_t state,
    output logic                        frame_error
);
    import synth_kbd_pkg::*;

    ps2_byte_t  rx_byte;
    key_event_t key_event;
    cmd_t       cmd;

    ps2_rx u_ps2_rx
    (
        .PS2_CLK (PS2_CLK),
        .reset   (reset),
        .kbd_clk (kbd_clk),
        .kbd_dat (kbd_dat),
        .rx_byte (rx_byte)
    );

    scancode_parser u_scancode_parser
    (
        .PS2_CLK   (PS2_CLK),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .key_event (key_event)
    );

    key_mapper u_key_mapper
    (
        .PS2_CLK   (PS2_CLK),
        .reset     (reset),
        .key_event (key_event),
        .cmd       (cmd),
        .note_out  (note_out)
    );

    synth_params u_synth_params
    (
        .PS2_CLK (PS2_CLK),
        .reset   (reset),
        .cmd     (cmd),
        .state   (state)
    );

    assign frame_error = rx_byte.error;  // Bad parity or stop bit

endmodule

// File: rtl/synth_params.sv
`timescale 1ns/1ps

module synth_params
(
    input  logic                        PS2_CLK,
    input  logic                        reset,
    input  synth_kbd_pkg::cmd_t         cmd,
    output synth_kbd_pkg::synth_state_t state
);
    import synth_kbd_pkg::*;

    logic signed [2:0]                octave_q;
    env_sel_t                         env_sel_q;
    logic [NUM_ENV-1:0][ENV_BITS-1:0] env_q;
    logic [ENV_BITS-1:0]              env_cur;    // Value under the selected slot
    logic                             sel_ok;

    assign sel_ok  = (env_sel_q < NUM_ENV);
    assign env_cur = sel_ok ? env_q[env_sel_q] : '0;

    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            octave_q  <= '0;
            env_sel_q <= '0;
            for (int i = 0; i < NUM_ENV; i++)
            begin
                env_q[i] <= ENV_BITS'(ENV_DEFAULT);
            end
        end
        else
        begin
            // Octave offset saturates at both ends
            if (cmd.octave_down && octave_q > OCT_MIN)
                octave_q <= octave_q - 3'sd1;
            else if (cmd.octave_up && octave_q < OCT_MAX)
                octave_q <= octave_q + 3'sd1;

            if (cmd.select)
                env_sel_q <= cmd.env_sel;

            if (sel_ok)
            begin
                if (cmd.env_down && env_cur != '0)
                    env_q[env_sel_q] <= env_cur - 1'b1;
                else if (cmd.env_up && env_cur != '1)
                    env_q[env_sel_q] <= env_cur + 1'b1;
            end
        end
    end

    assign state.octave  = octave_q;
    assign state.env_sel = env_sel_q;
    assign state.env     = env_q;

endmodule

// File: rtl/key_mapper.sv
`timescale 1ns/1ps

module key_mapper
(
    input  logic                      PS2_CLK,
    input  logic                      reset,
    input  synth_kbd_pkg::key_event_t key_event,
    output synth_kbd_pkg::cmd_t       cmd,
    output synth_kbd_pkg::note_out_t  note_out
);
    import synth_kbd_pkg::*;

    // Returns {hit, note number}
    function automatic logic [4:0] note_lookup(input logic [7:0] code);
        case (code)
            SC_A:    note_lookup = {1'b1, 4'd0};
            SC_W:    note_lookup = {1'b1, 4'd1};
            SC_S:    note_lookup = {1'b1, 4'd2};
            SC_E:    note_lookup = {1'b1, 4'd3};
            SC_D:    note_lookup = {1'b1, 4'd4};
            SC_F:    note_lookup = {1'b1, 4'd5};
            SC_T:    note_lookup = {1'b1, 4'd6};
            SC_G:    note_lookup = {1'b1, 4'd7};
            SC_Y:    note_lookup = {1'b1, 4'd8};
            SC_H:    note_lookup = {1'b1, 4'd9};
            SC_U:    note_lookup = {1'b1, 4'd10};
            SC_J:    note_lookup = {1'b1, 4'd11};
            default: note_lookup = {1'b0, 4'd0};
        endcase
    endfunction

    logic [4:0] lookup;
    logic       key_hit;
    logic [3:0] key_note;
    logic [3:0] note_q;
    logic       note_on_q;
    logic       gate_q;
    cmd_t       cmd_q;

    assign lookup   = note_lookup(key_event.code);
    assign key_hit  = lookup[4];
    assign key_note = lookup[3:0];

    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            note_q    <= '0;
            note_on_q <= 1'b0;
            gate_q    <= 1'b0;
            cmd_q     <= '0;
        end
        else
        begin
            note_on_q         <= 1'b0;
            cmd_q.octave_down <= 1'b0;
            cmd_q.octave_up   <= 1'b0;
            cmd_q.env_down    <= 1'b0;
            cmd_q.env_up      <= 1'b0;
            cmd_q.select      <= 1'b0;
            if (key_event.valid && !key_event.released)
            begin
                if (key_hit)
                begin
                    note_q    <= key_note;
                    note_on_q <= 1'b1;
                    gate_q    <= 1'b1;
                end
                else
                begin
                    case (key_event.code)
                        SC_Z:    cmd_q.octave_down <= 1'b1;
                        SC_X:    cmd_q.octave_up   <= 1'b1;
                        SC_1, SC_2, SC_3, SC_4, SC_5:
                        begin
                            cmd_q.select <= 1'b1;
                            case (key_event.code)
                                SC_1:    cmd_q.env_sel <= 3'd0;  // Volume
                                SC_2:    cmd_q.env_sel <= 3'd1;  // Attack
                                SC_3:    cmd_q.env_sel <= 3'd2;  // Decay
                                SC_4:    cmd_q.env_sel <= 3'd3;  // Sustain
                                default: cmd_q.env_sel <= 3'd4;  // Release
                            endcase
                        end
                        SC_C:    cmd_q.env_down <= 1'b1;
                        SC_V:    cmd_q.env_up   <= 1'b1;
                        default: ;
                    endcase
                end
            end
            else if (key_event.valid && key_hit && key_note == note_q)
                gate_q <= 1'b0;  // Held note released
        end
    end

    assign cmd              = cmd_q;
    assign note_out.note    = note_q;
    assign note_out.note_on = note_on_q;
    assign note_out.gate    = gate_q;

endmodule

// File: rtl/scancode_parser.sv
`timescale 1ns/1ps

module scancode_parser
(
    input  logic                      PS2_CLK,
    input  logic                      reset,
    input  synth_kbd_pkg::ps2_byte_t  rx_byte,
    output synth_kbd_pkg::key_event_t key_event
);
    import synth_kbd_pkg::*;

    logic       is_prefix;
    logic       brk_pend;   // F0 seen so the next code is a release
    logic       ext_pend;   // E0 seen so the next code gets dropped
    logic       ev_valid;
    logic       ev_release;
    logic [7:0] ev_code;

    assign is_prefix = (rx_byte.data == CODE_BREAK) || (rx_byte.data == CODE_EXT);

    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            brk_pend <= 1'b0;
            ext_pend <= 1'b0;
            ev_valid <= 1'b0;
        end
        else
        begin
            ev_valid <= 1'b0;
            if (rx_byte.error)
            begin
                brk_pend <= 1'b0;  // Sequence state is unreliable now
                ext_pend <= 1'b0;
            end
            else if (rx_byte.valid)
            begin
                if (rx_byte.data == CODE_BREAK)
                    brk_pend <= 1'b1;
                else if (rx_byte.data == CODE_EXT)
                    ext_pend <= 1'b1;
                else
                begin
                    ev_valid <= !ext_pend;
                    brk_pend <= 1'b0;
                    ext_pend <= 1'b0;
                end
            end
        end
    end

    // Event payload follows the last key code byte
    always_ff @(posedge PS2_CLK)
    begin
        if (rx_byte.valid && !is_prefix)
        begin
            ev_code    <= rx_byte.data;
            ev_release <= brk_pend;
        end
    end

    assign key_event.code     = ev_code;
    assign key_event.released = ev_release;
    assign key_event.valid    = ev_valid;

endmodule

// File: rtl/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx
(
    input  logic                     PS2_CLK,
    input  logic                     reset,
    input  logic                     kbd_clk,
    input  logic                     kbd_dat,
    output synth_kbd_pkg::ps2_byte_t rx_byte
);
    import synth_kbd_pkg::*;

    logic [1:0]                      clk_sync;
    logic [1:0]                      dat_sync;
    logic                            filt_clk;     // Debounced keyboard clock
    logic [$clog2(FILTER_LEN)-1:0]   filt_cnt;
    logic                            clk_fall;
    logic                            frame_ok;
    logic [3:0]                      bit_cnt;      // 0 means idle
    logic [$clog2(RX_TIMEOUT)-1:0]   idle_cnt;
    logic [7:0]                      shift_q;
    logic                            parity_q;
    logic [7:0]                      data_q;
    logic                            valid_q;
    logic                            error_q;

    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            clk_sync <= 2'b11;  // Both lines idle high
            dat_sync <= 2'b11;
        end
        else
        begin
            clk_sync <= {clk_sync[0], kbd_clk};
            dat_sync <= {dat_sync[0], kbd_dat};
        end
    end

    // New level only after FILTER_LEN differing samples in a row
    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            filt_clk <= 1'b1;
            filt_cnt <= '0;
        end
        else if (clk_sync[1] == filt_clk)
            filt_cnt <= '0;
        else if (filt_cnt == FILTER_LEN - 1)
        begin
            filt_clk <= clk_sync[1];
            filt_cnt <= '0;
        end
        else
            filt_cnt <= filt_cnt + 1'b1;
    end

    assign clk_fall = filt_clk && !clk_sync[1] && (filt_cnt == FILTER_LEN - 1);
    assign frame_ok = dat_sync[1] && (^{shift_q, parity_q});  // Stop high, odd parity

    always_ff @(posedge PS2_CLK)
    begin
        if (reset)
        begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            valid_q  <= 1'b0;
            error_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            error_q <= 1'b0;
            if (clk_fall)
            begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd0)
                begin
                    if (!dat_sync[1])
                        bit_cnt <= 4'd1;  // Start bit seen
                end
                else if (bit_cnt == 4'd10)
                begin
                    bit_cnt <= '0;
                    valid_q <= frame_ok;
                    error_q <= !frame_ok;
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
            else if (bit_cnt != 4'd0)
            begin
                if (idle_cnt == RX_TIMEOUT - 1)
                begin
                    bit_cnt  <= '0;  // Drop the partial frame
                    idle_cnt <= '0;
                end
                else
                    idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge PS2_CLK)
    begin
        if (clk_fall)
        begin
            if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
                shift_q <= {dat_sync[1], shift_q[7:1]};  // LSB first
            if (bit_cnt == 4'd9)
                parity_q <= dat_sync[1];
            if (bit_cnt == 4'd10 && frame_ok)
                data_q <= shift_q;
        end
    end

    assign rx_byte.data  = data_q;
    assign rx_byte.valid = valid_q;
    assign rx_byte.error = error_q;

endmodule

// File: rtl/synth_kbd_pkg.sv
package synth_kbd_pkg;

    localparam int FILTER_LEN  = 8;     // Equal kbd_clk samples to accept a level
    localparam int RX_TIMEOUT  = 2048;  // Cycles without a falling edge mid-frame
    localparam int NUM_NOTES   = 12;
    localparam int NUM_ENV     = 5;     // Volume, attack, decay, sustain, release
    localparam int ENV_BITS    = 4;
    localparam int ENV_DEFAULT = 8;
    localparam int OCT_MIN     = -3;
    localparam int OCT_MAX     = 3;

    localparam logic [7:0] CODE_BREAK = 8'hF0;
    localparam logic [7:0] CODE_EXT   = 8'hE0;

    // Note keys from C up to B
    localparam logic [7:0] SC_A = 8'h1C;
    localparam logic [7:0] SC_W = 8'h1D;
    localparam logic [7:0] SC_S = 8'h1B;
    localparam logic [7:0] SC_E = 8'h24;
    localparam logic [7:0] SC_D = 8'h23;
    localparam logic [7:0] SC_F = 8'h2B;
    localparam logic [7:0] SC_T = 8'h2C;
    localparam logic [7:0] SC_G = 8'h34;
    localparam logic [7:0] SC_Y = 8'h35;
    localparam logic [7:0] SC_H = 8'h33;
    localparam logic [7:0] SC_U = 8'h3C;
    localparam logic [7:0] SC_J = 8'h3B;

    localparam logic [7:0] SC_Z = 8'h1A;  // Octave down
    localparam logic [7:0] SC_X = 8'h22;  // Octave up
    localparam logic [7:0] SC_1 = 8'h16;  // Envelope slot selects
    localparam logic [7:0] SC_2 = 8'h1E;
    localparam logic [7:0] SC_3 = 8'h26;
    localparam logic [7:0] SC_4 = 8'h25;
    localparam logic [7:0] SC_5 = 8'h2E;
    localparam logic [7:0] SC_C = 8'h21;  // Selected value down
    localparam logic [7:0] SC_V = 8'h2A;  // Selected value up

    typedef logic [2:0] env_sel_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       error;
    } ps2_byte_t;

    typedef struct packed {
        logic [7:0] code;
        logic       released;
        logic       valid;
    } key_event_t;

    typedef struct packed {
        logic     octave_down;
        logic     octave_up;
        logic     env_down;
        logic     env_up;
        logic     select;
        env_sel_t env_sel;
    } cmd_t;

    typedef struct packed {
        logic signed [2:0]                   octave;
        env_sel_t                            env_sel;
        logic [NUM_ENV-1:0][ENV_BITS-1:0]    env;      // Index 0 is volume
    } synth_state_t;

    typedef struct packed {
        logic [$clog2(NUM_NOTES)-1:0] note;
        logic                         note_on;
        logic                         gate;
    } note_out_t;

endpackage
